// File: files.f
hdl/pdp8Pkg.sv
hdl/chkrPkg.sv
hdl/execMonitor.sv
hdl/ruleTally.sv
hdl/tallyReader.sv
hdl/execUnitChkr.sv
verif/execUnitChkrTb.sv

// File: run.sh
#!/bin/sh
# Build and run the execution-unit checker testbench with Verilator

cd "$(dirname "$0")" || exit 1
LOG=sim.log

verilator --binary --timing --assert -Wno-fatal -f files.f \
    --top-module execUnitChkrTb -Mdir obj_dir -o simv
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/simv > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "Result: FAILED" "$LOG"; then
    exit 1
fi
exit 0

// File: verif/execUnitChkrTb.sv
`timescale 1ns/10ps
`default_nettype none

module execUnitChkrTb;
    import pdp8Pkg::*;
    import chkrPkg::*;

    localparam int ClkPeriod = 4;
    // Instruction kinds played by the execution-unit model
    localparam int KNop = 0, KClaCll = 1, KAnd = 2, KTad = 3, KDca = 4;
    localparam int KJmp = 5, KJms = 6, KIsz = 7, KIllegal = 8;
    // Injected faults
    localparam int FNone = 0, FRdAddr = 1, FJmsData = 2, FLongStall = 3, FJmpPc = 4;
    localparam int FromMem = -1;
    // 15 instructions of up to 8 cycles, 8 sweeps of 10 cycles, reset and margin
    localparam int TimeoutCycles = 15 * 8 + 8 * 10 + 16 + 200;

    logic clk;
    logic reset_n;
    addrT baseAddr;
    memOpcodeT memOpcode;
    op7OpcodeT op7Opcode;
    logic stall;
    addrT pcValue;
    logic execRdReq;
    addrT execRdAddr;
    dataT execRdData;
    logic execWrReq;
    addrT execWrAddr;
    dataT execWrData;
    ruleT ruleSel;
    logic [15:0] selRunCount;
    logic [15:0] selFailCount;
    logic anyFail;

    int seed;
    int errors;
    int checks;
    addrT pc;
    logic firstInstr;
    dataT mem [16];
    logic [15:0] expRun [8];
    logic [15:0] expFail [8];

    execUnitChkr #(.CountWidth(16)) dut_i (.*);

    initial begin
        clk = 1'b0;
        forever #(ClkPeriod / 2) clk = ~clk;
    end

    initial begin
        #(TimeoutCycles * ClkPeriod);
        $display("Watchdog expired after %0d cycles before the tests finished", TimeoutCycles);
        $display("Result: FAILED");
        $finish;
    end

    task automatic tick;
        @(posedge clk);
        #1;
    endtask

    task automatic score(input ruleT rule, input logic pass);
        expRun[rule] = expRun[rule] + 16'd1;
        if (!pass) begin
            expFail[rule] = expFail[rule] + 16'd1;
        end
    endtask

    task automatic clearExpected;
        for (int r = 0; r < 8; r++) begin
            expRun[r] = '0;
            expFail[r] = '0;
        end
        firstInstr = 1'b1;
    endtask

    task automatic compare(input string name, input int r, input logic [15:0] got,
                           input logic [15:0] exp);
        checks++;
        assert (got == exp) else begin
            $display("FAIL %s (ruleSel %0d): got 0x%h expected 0x%h", name, r, got, exp);
            errors++;
        end
    endtask

    // Plays one instruction the way the execution unit would
    task automatic playInstr(input int kind, input int fault, input int rdOverride);
        addrT opAddr;
        addrT rdAddr;
        addrT newPc;
        dataT rdWord;
        dataT wrData;
        logic isRd;
        logic isWr;
        int len;
        int wrCycle;
        opAddr = addrT'($random(seed));
        rdWord = (rdOverride < 0) ? mem[opAddr[3:0]] : dataT'(rdOverride);
        rdAddr = (fault == FRdAddr) ? opAddr ^ 12'h001 : opAddr;
        isRd = (kind == KAnd) || (kind == KTad) || (kind == KIsz);
        isWr = (kind == KDca) || (kind == KJms) || (kind == KIsz);
        len = (kind == KAnd || kind == KTad) ? 4 : (kind == KIsz) ? 5 : 3;
        len = len + ((fault == FLongStall) ? 1 : 0);
        wrCycle = (kind == KIsz) ? 3 : 1;
        if (kind == KJmp) newPc = (fault == FJmpPc) ? opAddr + 12'd1 : opAddr;
        else if (kind == KJms) newPc = opAddr + 12'd1;
        else if (kind == KIsz && rdWord == 12'hfff) newPc = pc + 12'd2;
        else if (kind == KIllegal) newPc = pc;
        else newPc = pc + 12'd1;
        if (kind == KIsz) wrData = rdWord + 12'd1;
        else if (kind == KJms) wrData = (fault == FJmsData) ? pc + 12'd2 : pc + 12'd1;
        else wrData = dataT'($random(seed));

        // Expected verdicts for this instruction
        if (firstInstr) begin
            score(RuleStartAddr, 1'b1);
            firstInstr = 1'b0;
        end
        score(RuleLegal, kind != KIllegal);
        if (kind != KIllegal) begin
            score(RuleCycles, fault != FLongStall);
            score(RulePc, fault != FJmpPc);
            if (isRd || kind == KDca || kind == KJms) score(RuleMemAddr, fault != FRdAddr);
            if (kind == KIsz || kind == KJms) score(RuleWrData, fault != FJmsData);
        end

        tick;
        memOpcode = '0;
        op7Opcode = '0;
        memOpcode.memInstAddr = opAddr;
        case (kind)
            KNop: op7Opcode.NOP = 1'b1;
            KClaCll: op7Opcode.CLA_CLL = 1'b1;
            KAnd: memOpcode.AND = 1'b1;
            KTad: memOpcode.TAD = 1'b1;
            KDca: memOpcode.DCA = 1'b1;
            KJmp: memOpcode.JMP = 1'b1;
            KJms: memOpcode.JMS = 1'b1;
            KIsz: memOpcode.ISZ = 1'b1;
            default: begin
                memOpcode.AND = 1'b1;
                op7Opcode.NOP = 1'b1;
            end
        endcase
        stall = 1'b1;
        tick;
        // Address and data buses hold the right value only in their valid cycle
        for (int c = 1; c < len; c++) begin
            execRdReq = isRd && (c == 1);
            execRdAddr = execRdReq ? rdAddr : ~rdAddr;
            execRdData = (c == 2) ? rdWord : ~rdWord;
            execWrReq = isWr && (c == wrCycle);
            execWrAddr = execWrReq ? opAddr : ~opAddr;
            execWrData = execWrReq ? wrData : ~wrData;
            tick;
        end
        execRdReq = 1'b0;
        execWrReq = 1'b0;
        stall = 1'b0;
        pc = newPc;
        pcValue = newPc;
        memOpcode = '0;
        op7Opcode = '0;
        tick;
    endtask

    // Sweeps every rule number through the reader and checks the counts
    task automatic checkCounts;
        logic expAny;
        expAny = 1'b0;
        for (int r = 0; r < NumRules; r++) begin
            expAny = expAny | (expFail[r] != '0);
        end
        repeat (2) tick;
        for (int r = 0; r < 8; r++) begin
            ruleSel = ruleT'(r[2:0]);
            tick;
            compare("selRunCount", r, selRunCount, expRun[r]);
            compare("selFailCount", r, selFailCount, expFail[r]);
        end
        compare("anyFail", 0, {15'd0, anyFail}, {15'd0, expAny});
    endtask

    initial begin
        seed = 32'h1390;
        errors = 0;
        checks = 0;
        reset_n = 1'b0;
        baseAddr = StartAddress;
        pc = StartAddress;
        pcValue = StartAddress;
        memOpcode = '0;
        op7Opcode = '0;
        stall = 1'b0;
        execRdReq = 1'b0;
        execRdAddr = '0;
        execRdData = '0;
        execWrReq = 1'b0;
        execWrAddr = '0;
        execWrData = '0;
        ruleSel = RuleStartAddr;
        for (int i = 0; i < 16; i++) begin
            mem[i] = dataT'($random(seed));
        end
        clearExpected();
        repeat (8) @(posedge clk);
        #1 reset_n = 1'b1;

        // Clean sequence where the first one also judges the start address
        playInstr(KNop, FNone, FromMem);
        playInstr(KClaCll, FNone, FromMem);
        playInstr(KAnd, FNone, FromMem);
        playInstr(KTad, FNone, FromMem);
        playInstr(KDca, FNone, FromMem);
        playInstr(KJmp, FNone, FromMem);
        playInstr(KJms, FNone, FromMem);
        playInstr(KIsz, FNone, FromMem);
        checkCounts();

        // ISZ skip on wrap and no skip otherwise
        playInstr(KIsz, FNone, 12'hfff);
        playInstr(KIsz, FNone, 12'h123);
        checkCounts();

        playInstr(KAnd, FRdAddr, FromMem);
        checkCounts();
        playInstr(KJms, FJmsData, FromMem);
        checkCounts();
        playInstr(KNop, FLongStall, FromMem);
        checkCounts();
        playInstr(KJmp, FJmpPc, FromMem);
        checkCounts();
        playInstr(KIllegal, FNone, FromMem);
        checkCounts();

        // Reset in the middle of the run clears everything
        reset_n = 1'b0;
        repeat (8) tick;
        reset_n = 1'b1;
        clearExpected();
        checkCounts();

        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: hdl/execUnitChkr.sv
`timescale 1ns/10ps
`default_nettype none

module execUnitChkr #(
    parameter int CountWidth = 16
) (
    input  wire logic               clk,
    input  wire logic               reset_n,
    // Observed execution unit
    input  wire pdp8Pkg::addrT      baseAddr,
    input  wire pdp8Pkg::memOpcodeT memOpcode,
    input  wire pdp8Pkg::op7OpcodeT op7Opcode,
    input  wire logic               stall,
    input  wire pdp8Pkg::addrT      pcValue,
    input  wire logic               execRdReq,
    input  wire pdp8Pkg::addrT      execRdAddr,
    input  wire pdp8Pkg::dataT      execRdData,
    input  wire logic               execWrReq,
    input  wire pdp8Pkg::addrT      execWrAddr,
    input  wire pdp8Pkg::dataT      execWrData,
    // Count readback
    input  wire chkrPkg::ruleT      ruleSel,
    output logic [CountWidth-1:0]   selRunCount,
    output logic [CountWidth-1:0]   selFailCount,
    output logic                    anyFail
);
    import chkrPkg::*;

    ruleVecT                             ruleRun;
    ruleVecT                             rulePass;
    logic [NumRules-1:0][CountWidth-1:0] runCounts;
    logic [NumRules-1:0][CountWidth-1:0] failCounts;

    execMonitor monitor_i (
        .clk        (clk),
        .reset_n    (reset_n),
        .baseAddr   (baseAddr),
        .memOpcode  (memOpcode),
        .op7Opcode  (op7Opcode),
        .stall      (stall),
        .pcValue    (pcValue),
        .execRdReq  (execRdReq),
        .execRdAddr (execRdAddr),
        .execRdData (execRdData),
        .execWrReq  (execWrReq),
        .execWrAddr (execWrAddr),
        .execWrData (execWrData),
        .ruleRun    (ruleRun),
        .rulePass   (rulePass)
    );

    // One tally per rule
    for (genvar i = 0; i < NumRules; i++) begin : gTally
        ruleTally #(
            .CountWidth (CountWidth)
        ) tally_i (
            .clk       (clk),
            .reset_n   (reset_n),
            .run       (ruleRun[i]),
            .pass      (rulePass[i]),
            .runCount  (runCounts[i]),
            .failCount (failCounts[i])
        );
    end

    tallyReader #(
        .CountWidth (CountWidth)
    ) reader_i (
        .clk          (clk),
        .reset_n      (reset_n),
        .runCounts    (runCounts),
        .failCounts   (failCounts),
        .ruleSel      (ruleSel),
        .selRunCount  (selRunCount),
        .selFailCount (selFailCount),
        .anyFail      (anyFail)
    );

endmodule

`default_nettype wire

// File: hdl/tallyReader.sv
`timescale 1ns/10ps
`default_nettype none

module tallyReader #(
    parameter int CountWidth = 16
) (
    input  wire logic                                       clk,
    input  wire logic                                       reset_n,
    input  wire logic [chkrPkg::NumRules-1:0][CountWidth-1:0] runCounts,
    input  wire logic [chkrPkg::NumRules-1:0][CountWidth-1:0] failCounts,
    input  wire chkrPkg::ruleT                              ruleSel,
    output logic [CountWidth-1:0]                           selRunCount,
    output logic [CountWidth-1:0]                           selFailCount,
    output logic                                            anyFail
);
    import chkrPkg::*;

    always_ff @(posedge clk) begin
        if (!reset_n) begin
            selRunCount  <= '0;
            selFailCount <= '0;
            anyFail      <= 1'b0;
        end else begin
            // Unused rule numbers read back as zero
            if (ruleSel < NumRules) begin
                selRunCount  <= runCounts[ruleSel];
                selFailCount <= failCounts[ruleSel];
            end else begin
                selRunCount  <= '0;
                selFailCount <= '0;
            end
            anyFail <= |failCounts;
        end
    end

endmodule

`default_nettype wire

// File: hdl/ruleTally.sv
`timescale 1ns/10ps
`default_nettype none

module ruleTally #(
    parameter int CountWidth = 16
) (
    input  wire logic                  clk,
    input  wire logic                  reset_n,
    input  wire logic                  run,
    input  wire logic                  pass,
    output logic [CountWidth-1:0]      runCount,
    output logic [CountWidth-1:0]      failCount
);

    // Both counters stick at all ones
    always_ff @(posedge clk) begin
        if (!reset_n) begin
            runCount  <= '0;
            failCount <= '0;
        end else if (run) begin
            if (runCount != '1) begin
                runCount <= runCount + 1'b1;
            end
            if (!pass && (failCount != '1)) begin
                failCount <= failCount + 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

// File: hdl/execMonitor.sv
`timescale 1ns/10ps
`default_nettype none

module execMonitor (
    input  wire logic               clk,
    input  wire logic               reset_n,
    // Decoder side
    input  wire pdp8Pkg::addrT      baseAddr,
    input  wire pdp8Pkg::memOpcodeT memOpcode,
    input  wire pdp8Pkg::op7OpcodeT op7Opcode,
    input  wire logic               stall,
    input  wire pdp8Pkg::addrT      pcValue,
    // Memory side
    input  wire logic               execRdReq,
    input  wire pdp8Pkg::addrT      execRdAddr,
    input  wire pdp8Pkg::dataT      execRdData,
    input  wire logic               execWrReq,
    input  wire pdp8Pkg::addrT      execWrAddr,
    input  wire pdp8Pkg::dataT      execWrData,
    // One bit per rule, valid for a single cycle
    output chkrPkg::ruleVecT        ruleRun,
    output chkrPkg::ruleVecT        rulePass
);
    import pdp8Pkg::*;
    import chkrPkg::*;

    localparam int NumFlags = 6 + $bits(op7OpcodeT);

    typedef enum logic {Idle, Track} stateT;

    stateT               state;
    logic                stallQ;
    logic                firstPending;
    logic [2:0]          stallLen;
    logic                rdSeen;
    logic                rdDue;
    logic                rdValid;
    logic                wrSeen;

    memOpcodeT           curOp;
    addrT                oldPc;
    addrT                rdAddr;
    dataT                rdData;
    addrT                wrAddr;
    dataT                wrData;

    logic [NumFlags-1:0] flags;
    logic                anyFlag;
    logic                oneFlag;
    logic                tracking;
    logic                startNow;
    logic                endNow;
    logic                rdCapture;
    logic                wrCapture;

    logic                isRdOp;
    logic                isWrOp;
    logic [2:0]          expCycles;
    addrT                pcPlusOne;
    dataT                rdPlusOne;
    addrT                expPc;
    logic                memAddrOk;
    logic                wrDataOk;

    assign flags = {memOpcode.AND, memOpcode.TAD, memOpcode.ISZ,
                    memOpcode.DCA, memOpcode.JMS, memOpcode.JMP, op7Opcode};
    assign anyFlag = |flags;
    // Clearing the lowest set bit leaves zero only when a single flag is set
    assign oneFlag = anyFlag && ((flags & (flags - 1'b1)) == '0);

    assign tracking  = (state == Track);
    assign startNow  = (state == Idle) && anyFlag && stall && !stallQ;
    assign endNow    = tracking && !stall;
    assign rdCapture = tracking && execRdReq && !rdSeen;
    assign wrCapture = tracking && execWrReq && !wrSeen;

    // Expected behaviour of the instruction being followed
    assign isRdOp    = curOp.AND || curOp.TAD || curOp.ISZ;
    assign isWrOp    = curOp.DCA || curOp.JMS;
    assign pcPlusOne = oldPc + 1'b1;
    assign rdPlusOne = rdData + 1'b1;

    // Operate instructions all behave like NOP
    always_comb begin
        if (curOp.AND || curOp.TAD) begin
            expCycles = CyclesAndTad;
        end else if (curOp.ISZ) begin
            expCycles = CyclesIsz;
        end else if (curOp.DCA) begin
            expCycles = CyclesDca;
        end else if (curOp.JMS) begin
            expCycles = CyclesJms;
        end else if (curOp.JMP) begin
            expCycles = CyclesJmp;
        end else begin
            expCycles = CyclesOperate;
        end
    end

    always_comb begin
        if (curOp.JMP) begin
            expPc = curOp.memInstAddr;
        end else if (curOp.JMS) begin
            expPc = curOp.memInstAddr + 1'b1;
        end else if (curOp.ISZ && (rdPlusOne == '0)) begin
            // Skip when the incremented word wraps to zero
            expPc = oldPc + 2'd2;
        end else begin
            expPc = pcPlusOne;
        end
    end

    // A missing request fails both memory rules
    assign memAddrOk = isRdOp ? (rdSeen && (rdAddr == curOp.memInstAddr))
                              : (wrSeen && (wrAddr == curOp.memInstAddr));
    assign wrDataOk  = curOp.ISZ ? (wrSeen && rdValid && (wrData == rdPlusOne))
                                 : (wrSeen && (wrData == pcPlusOne));

    // Instruction tracking FSM and request bookkeeping
    always_ff @(posedge clk) begin
        if (!reset_n) begin
            state        <= Idle;
            stallQ       <= 1'b0;
            firstPending <= 1'b1;
            stallLen     <= '0;
            rdSeen       <= 1'b0;
            rdDue        <= 1'b0;
            rdValid      <= 1'b0;
            wrSeen       <= 1'b0;
        end else begin
            stallQ <= stall;
            if (startNow) begin
                firstPending <= 1'b0;
                stallLen     <= 3'd1;
                rdSeen       <= 1'b0;
                rdDue        <= 1'b0;
                rdValid      <= 1'b0;
                wrSeen       <= 1'b0;
                // Illegal opcodes are judged at the start and not followed
                if (oneFlag) begin
                    state <= Track;
                end
            end else if (tracking) begin
                if (stall && (stallLen != '1)) begin
                    stallLen <= stallLen + 1'b1;
                end
                if (rdCapture) begin
                    rdSeen <= 1'b1;
                    rdDue  <= 1'b1;
                end
                if (rdDue) begin
                    rdDue   <= 1'b0;
                    rdValid <= 1'b1;
                end
                if (wrCapture) begin
                    wrSeen <= 1'b1;
                end
                if (endNow) begin
                    state <= Idle;
                end
            end
        end
    end

    // Captured instruction and memory traffic
    always_ff @(posedge clk) begin
        if (startNow) begin
            curOp <= memOpcode;
            oldPc <= pcValue;
        end
        if (rdCapture) begin
            rdAddr <= execRdAddr;
        end
        if (tracking && rdDue) begin
            rdData <= execRdData;
        end
        if (wrCapture) begin
            wrAddr <= execWrAddr;
            wrData <= execWrData;
        end
    end

    // Verdict strobes
    always_ff @(posedge clk) begin
        if (!reset_n) begin
            ruleRun  <= '0;
            rulePass <= '0;
        end else begin
            ruleRun  <= '0;
            rulePass <= '0;
            if (startNow) begin
                ruleRun[RuleLegal]  <= 1'b1;
                rulePass[RuleLegal] <= oneFlag;
                if (firstPending) begin
                    ruleRun[RuleStartAddr]  <= 1'b1;
                    rulePass[RuleStartAddr] <= (baseAddr == StartAddress) &&
                                               (pcValue == baseAddr);
                end
            end
            if (endNow) begin
                ruleRun[RuleCycles]  <= 1'b1;
                rulePass[RuleCycles] <= (stallLen == expCycles);
                ruleRun[RulePc]      <= 1'b1;
                rulePass[RulePc]     <= (pcValue == expPc);
                if (isRdOp || isWrOp) begin
                    ruleRun[RuleMemAddr]  <= 1'b1;
                    rulePass[RuleMemAddr] <= memAddrOk;
                end
                if (curOp.ISZ || curOp.JMS) begin
                    ruleRun[RuleWrData]  <= 1'b1;
                    rulePass[RuleWrData] <= wrDataOk;
                end
            end
        end
    end

endmodule

`default_nettype wire

// File: hdl/chkrPkg.sv
`default_nettype none

package chkrPkg;

    localparam int NumRules = 6;

    // Rule identifiers, also the bit index into a rule vector
    typedef enum logic [2:0] {
        RuleStartAddr = 3'd0,
        RuleLegal     = 3'd1,
        RuleCycles    = 3'd2,
        RulePc        = 3'd3,
        RuleMemAddr   = 3'd4,
        RuleWrData    = 3'd5
    } ruleT;

    typedef logic [NumRules-1:0] ruleVecT;

    // Expected stall length per opcode, counted in clock edges
    // from the stall rise to the first edge with stall low
    localparam logic [2:0] CyclesOperate = 3'd3;
    localparam logic [2:0] CyclesAndTad  = 3'd4;
    localparam logic [2:0] CyclesIsz     = 3'd5;
    localparam logic [2:0] CyclesDca     = 3'd3;
    localparam logic [2:0] CyclesJms     = 3'd3;
    localparam logic [2:0] CyclesJmp     = 3'd3;

endpackage

`default_nettype wire

// File: hdl/pdp8Pkg.sv
`default_nettype none

package pdp8Pkg;

    // Word address and memory word are the same size on a PDP-8
    localparam int AddrWidth = 12;
    localparam int DataWidth = 12;

    typedef logic [AddrWidth-1:0] addrT;
    typedef logic [DataWidth-1:0] dataT;

    // First instruction fetch, octal 200
    localparam addrT StartAddress = 12'o200;

    // Decoded memory reference instruction with its effective address
    typedef struct packed {
        logic AND;
        logic TAD;
        logic ISZ;
        logic DCA;
        logic JMS;
        logic JMP;
        addrT memInstAddr;
    } memOpcodeT;

    // Group operate micro-instructions, one flag each
    typedef struct packed {
        logic NOP;
        logic IAC;
        logic RAL;
        logic RTL;
        logic RAR;
        logic RTR;
        logic CML;
        logic CMA;
        logic CIA;
        logic CLL;
        logic CLA1;
        logic CLA_CLL;
        logic HLT;
        logic OSR;
        logic SKP;
        logic SNL;
        logic SZL;
        logic SZA;
        logic SNA;
        logic SMA;
        logic SPA;
        logic CLA2;
    } op7OpcodeT;

endpackage

`default_nettype wire
